//--- verilog.f
source/iq_stream_pkg.sv
source/iq_pattern_rom.sv
source/iq_frame_gen.sv
source/axis_fifo.sv
source/iq_frame_accum.sv
source/iq_stream_top.sv
verification/iq_stream_checker.sv
verification/tb_iq_stream.sv

//--- Makefile
# Verilator build and run of the IQ stream testbench.

TOP := tb_iq_stream

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

//--- verification/tb_iq_stream.sv
//**************************************************************************
// IQ stream testbench
// Random start, stop and hold stimulus around the IQ stream top level.
//**************************************************************************

`timescale 1ns/1ps

module tb_iq_stream;

    import iq_stream_pkg::*;

    localparam int          FRAMES_WANTED  = 20;
    localparam int          QUIET_CYCLES   = 4 * FRAME_LEN;
    localparam int          STOP_MARGIN    = 2048;
    // Frames x beats x 2 cycles per beat x back-pressure factor, plus quiet start and stop gaps.
    localparam int          TIMEOUT_CYCLES = FRAMES_WANTED * FRAME_LEN * 2 * 4 + QUIET_CYCLES
                                             + STOP_MARGIN;
    localparam logic [31:0] LFSR_SEED      = 32'd78494;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic                    clk;
    logic                    rstn;
    logic                    start;
    logic                    stop;
    logic                    hold;
    logic signed [SUM_W-1:0] sum_i;
    logic signed [SUM_W-1:0] sum_q;
    logic                    sum_valid;
    logic                    run_end;
    logic                    timed_out;
    int                      error_count;
    int                      pulse_count;
    logic [31:0]             lfsr_state;

    iq_stream_top iq_stream_top_i (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .start_i    (start),
        .stop_i     (stop),
        .hold_i     (hold),
        .sum_i_o    (sum_i),
        .sum_q_o    (sum_q),
        .sum_valid_o(sum_valid)
    );

    iq_stream_checker #(.FRAMES_WANTED(FRAMES_WANTED)) iq_stream_checker_i (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .start_i      (start),
        .sum_i_i      (sum_i),
        .sum_q_i      (sum_q),
        .sum_valid_i  (sum_valid),
        .run_end_i    (run_end),
        .error_count_o(error_count),
        .pulse_count_o(pulse_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, one step per bit.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    task automatic take_bits(input int n, output int unsigned value);
        int k;
        value = 0;
        for (k = 0; k < n; k++) begin
            value = (value << 1) | {31'd0, lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    initial begin
        int unsigned r;
        int          gap_left;
        int          hold_left;
        int          cycles;
        lfsr_state = LFSR_SEED;
        rstn       = 1'b0;
        start      = 1'b0;
        stop       = 1'b0;
        hold       = 1'b0;
        run_end    = 1'b0;
        timed_out  = 1'b0;
        // No start for longer than a frame, so a self-starting generator shows up.
        gap_left   = QUIET_CYCLES;
        hold_left  = 0;
        cycles     = 0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        while (pulse_count < FRAMES_WANTED && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
            start = 1'b0;
            stop  = 1'b0;
            // Hold bursts of 8 to 39 cycles, about a quarter of the time, fill the FIFO.
            if (hold_left > 0) begin
                hold_left--;
            end else begin
                take_bits(6, r);
                if (r == 0) begin
                    take_bits(5, r);
                    hold_left = int'(r) + 8;
                end
            end
            hold = (hold_left > 0);
            if (gap_left > 0) begin
                gap_left--;
                start = (gap_left == 0);
            end else begin
                take_bits(7, r);
                if (r == 0) begin
                    stop = 1'b1;
                    take_bits(5, r);
                    gap_left = int'(r) + 1;
                end
            end
        end
        if (pulse_count < FRAMES_WANTED) begin
            timed_out = 1'b1;
            $display("Timeout: %0d of %0d frames done after %0d cycles",
                     pulse_count, FRAMES_WANTED, cycles);
        end
        run_end = 1'b1;
        @(posedge clk);
        #1;
        $display("Errors: %0d, frame sums seen: %0d", error_count, pulse_count);
        if (error_count == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verification/iq_stream_checker.sv
//**************************************************************************
// IQ stream checker
// Compares each frame's I and Q sums with a model of the pattern table.
//**************************************************************************

`timescale 1ns/1ps

module iq_stream_checker #(
    parameter int FRAMES_WANTED = 20
) (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  logic                                   start_i,
    input  logic signed [iq_stream_pkg::SUM_W-1:0] sum_i_i,
    input  logic signed [iq_stream_pkg::SUM_W-1:0] sum_q_i,
    input  logic                                   sum_valid_i,
    input  logic                                   run_end_i,
    output int                                     error_count_o,
    output int                                     pulse_count_o
);

    import iq_stream_pkg::*;

    logic signed [SUM_W-1:0] exp_i;
    logic signed [SUM_W-1:0] exp_q;
    logic                    started     = 1'b0;
    logic                    prev_valid  = 1'b0;
    logic                    end_checked = 1'b0;
    int                      errors      = 0;
    int                      pulses      = 0;

    assign error_count_o = errors;
    assign pulse_count_o = pulses;

    // Every frame carries the same table: i = 7*addr, q = 100 - 3*addr, 8-bit signed.
    initial begin
        logic signed [PART_W-1:0] part_i;
        logic signed [PART_W-1:0] part_q;
        int                       a;
        exp_i = '0;
        exp_q = '0;
        for (a = 0; a < FRAME_LEN; a++) begin
            part_i = PART_W'(a * 7);
            part_q = PART_W'(100 - a * 3);
            exp_i  = exp_i + SUM_W'(int'(part_i));
            exp_q  = exp_q + SUM_W'(int'(part_q));
        end
    end

    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (sum_valid_i) begin
                pulses++;
                if (!started) begin
                    $display("Error: sum_valid_o went high before the first start_i");
                    errors++;
                end
                if (prev_valid) begin
                    $display("Error: sum_valid_o stayed high for two cycles in a row");
                    errors++;
                end
                if (sum_i_i !== exp_i) begin
                    $display("[FAIL] sum_i_o: got 0x%04h, expected 0x%04h", sum_i_i, exp_i);
                    errors++;
                end
                if (sum_q_i !== exp_q) begin
                    $display("[FAIL] sum_q_o: got 0x%04h, expected 0x%04h", sum_q_i, exp_q);
                    errors++;
                end
            end
            if (start_i) begin
                started = 1'b1;
            end
            prev_valid = sum_valid_i;
        end
        if (run_end_i && !end_checked) begin
            end_checked = 1'b1;
            if (pulses < FRAMES_WANTED) begin
                $display("Error: frames went missing, only %0d of %0d frame sums seen",
                         pulses, FRAMES_WANTED);
                errors++;
            end
        end
    end

endmodule

//--- source/iq_stream_top.sv
//**************************************************************************
// IQ stream top
// Frame generator, FIFO and frame accumulator in one stream.
//**************************************************************************

`timescale 1ns/1ps

module iq_stream_top (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  logic                                   start_i,
    input  logic                                   stop_i,
    input  logic                                   hold_i,
    output logic signed [iq_stream_pkg::SUM_W-1:0] sum_i_o,
    output logic signed [iq_stream_pkg::SUM_W-1:0] sum_q_o,
    output logic                                   sum_valid_o
);

    import iq_stream_pkg::*;

    // Generator to FIFO.
    logic [SAMPLE_W-1:0] gen_tdata;
    logic                gen_tlast;
    logic                gen_tvalid;
    logic                gen_tready;

    // FIFO to accumulator.
    logic [SAMPLE_W-1:0] acc_tdata;
    logic                acc_tlast;
    logic                acc_tvalid;
    logic                acc_tready;

    iq_frame_gen iq_frame_gen_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .start_i   (start_i),
        .stop_i    (stop_i),
        .m_tdata_o (gen_tdata),
        .m_tlast_o (gen_tlast),
        .m_tvalid_o(gen_tvalid),
        .m_tready_i(gen_tready)
    );

    axis_fifo axis_fifo_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .s_tdata_i (gen_tdata),
        .s_tlast_i (gen_tlast),
        .s_tvalid_i(gen_tvalid),
        .s_tready_o(gen_tready),
        .m_tdata_o (acc_tdata),
        .m_tlast_o (acc_tlast),
        .m_tvalid_o(acc_tvalid),
        .m_tready_i(acc_tready)
    );

    iq_frame_accum iq_frame_accum_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .hold_i     (hold_i),
        .s_tdata_i  (acc_tdata),
        .s_tlast_i  (acc_tlast),
        .s_tvalid_i (acc_tvalid),
        .s_tready_o (acc_tready),
        .sum_i_o    (sum_i_o),
        .sum_q_o    (sum_q_o),
        .sum_valid_o(sum_valid_o)
    );

endmodule

//--- source/iq_frame_accum.sv
//**************************************************************************
// IQ frame accumulator
// Decodes signed I/Q pairs and reports the I and Q sums of each frame.
//**************************************************************************

`timescale 1ns/1ps

module iq_frame_accum (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  logic                                   hold_i,
    input  logic [iq_stream_pkg::SAMPLE_W-1:0]     s_tdata_i,
    input  logic                                   s_tlast_i,
    input  logic                                   s_tvalid_i,
    output logic                                   s_tready_o,
    output logic signed [iq_stream_pkg::SUM_W-1:0] sum_i_o,
    output logic signed [iq_stream_pkg::SUM_W-1:0] sum_q_o,
    output logic                                   sum_valid_o
);

    import iq_stream_pkg::*;

    iq_sample_t              s_word;
    logic signed [SUM_W-1:0] ext_i;
    logic signed [SUM_W-1:0] ext_q;
    logic signed [SUM_W-1:0] acc_i;
    logic signed [SUM_W-1:0] acc_q;
    logic                    accept;

    assign s_tready_o = ~hold_i;
    assign accept     = s_tvalid_i & s_tready_o;

    // Same word, read as an I/Q pair.
    assign s_word.raw = s_tdata_i;
    assign ext_i      = {{(SUM_W - PART_W){s_word.iq.i[PART_W-1]}}, s_word.iq.i};
    assign ext_q      = {{(SUM_W - PART_W){s_word.iq.q[PART_W-1]}}, s_word.iq.q};

    //**********************************************************************
    // Running sums
    //**********************************************************************

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            acc_i <= '0;
            acc_q <= '0;
        end else if (accept) begin
            if (s_tlast_i) begin
                acc_i <= '0;
                acc_q <= '0;
            end else begin
                acc_i <= acc_i + ext_i;
                acc_q <= acc_q + ext_q;
            end
        end
    end

    // Frame totals, captured with the tlast beat.
    always_ff @(posedge clk_i) begin
        if (accept && s_tlast_i) begin
            sum_i_o <= acc_i + ext_i;
            sum_q_o <= acc_q + ext_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= accept & s_tlast_i;
        end
    end

endmodule

//--- source/axis_fifo.sv
//**************************************************************************
// AXI-Stream FIFO
// Circular buffer for data words and their tlast bits.
//**************************************************************************

`timescale 1ns/1ps

module axis_fifo (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic [iq_stream_pkg::SAMPLE_W-1:0] s_tdata_i,
    input  logic                               s_tlast_i,
    input  logic                               s_tvalid_i,
    output logic                               s_tready_o,
    output logic [iq_stream_pkg::SAMPLE_W-1:0] m_tdata_o,
    output logic                               m_tlast_o,
    output logic                               m_tvalid_o,
    input  logic                               m_tready_i
);

    import iq_stream_pkg::*;

    logic [SAMPLE_W-1:0]   data_mem [FIFO_DEPTH];
    logic                  last_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;

    // Full refuses input even when a pop happens in the same cycle.
    assign s_tready_o = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign m_tvalid_o = (count != '0);
    assign push       = s_tvalid_i & s_tready_o;
    assign pop        = m_tvalid_o & m_tready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr] <= s_tdata_i;
            last_mem[wr_ptr] <= s_tlast_i;
        end
    end

    assign m_tdata_o = data_mem[rd_ptr];
    assign m_tlast_o = last_mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        count <= FIFO_CNT_W'(FIFO_DEPTH)
    ) else $error("axis_fifo: occupancy %0d above depth", count);

endmodule

//--- source/iq_frame_gen.sv
//**************************************************************************
// IQ frame generator
// Walks the pattern table and sends it as an AXI-Stream, tlast per frame.
//**************************************************************************

`timescale 1ns/1ps

module iq_frame_gen (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic                               start_i,
    input  logic                               stop_i,
    output logic [iq_stream_pkg::SAMPLE_W-1:0] m_tdata_o,
    output logic                               m_tlast_o,
    output logic                               m_tvalid_o,
    input  logic                               m_tready_i
);

    import iq_stream_pkg::*;

    logic                    en;
    logic                    fetch_q;
    logic [FRAME_ADDR_W-1:0] addr;
    logic                    addr_done;
    logic                    handshake;
    iq_sample_t              rom_data;

    assign handshake = m_tvalid_o & m_tready_i;
    assign addr_done = (addr == FRAME_ADDR_W'(FRAME_LEN - 1));

    // Stop wins over start.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            en <= 1'b0;
        end else if (stop_i) begin
            en <= 1'b0;
        end else if (start_i) begin
            en <= 1'b1;
        end
    end

    // Address moves only on a transferred beat, so a stop keeps the frame position.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            addr <= '0;
        end else if (handshake) begin
            addr <= addr_done ? '0 : addr + 1'b1;
        end
    end

    iq_pattern_rom iq_pattern_rom_i (
        .clk_i (clk_i),
        .addr_i(addr),
        .data_o(rom_data)
    );

    //**********************************************************************
    // Fetch then present
    //**********************************************************************

    // One cycle for the ROM read of the current address.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            fetch_q <= 1'b0;
        end else begin
            fetch_q <= en & ~fetch_q & (~m_tvalid_o | handshake);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            m_tvalid_o <= 1'b0;
            m_tlast_o  <= 1'b0;
        end else if (handshake) begin
            m_tvalid_o <= 1'b0;
            m_tlast_o  <= 1'b0;
        end else if (fetch_q && en) begin
            m_tvalid_o <= 1'b1;
            m_tlast_o  <= addr_done;
        end
    end

    // ROM output holds while the address holds.
    assign m_tdata_o = rom_data.raw;

    a_hold_stable : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) && $stable(m_tlast_o)
    ) else $error("iq_frame_gen: beat changed under back-pressure");

endmodule

//--- source/iq_pattern_rom.sv
//**************************************************************************
// IQ pattern ROM
// Synchronous-read table of one frame of pattern samples.
//**************************************************************************

`timescale 1ns/1ps

module iq_pattern_rom (
    input  logic                                   clk_i,
    input  logic [iq_stream_pkg::FRAME_ADDR_W-1:0] addr_i,
    output iq_stream_pkg::iq_sample_t              data_o
);

    import iq_stream_pkg::*;

    iq_sample_t rom_table [FRAME_LEN];

    // Table contents are constant, fixed at elaboration.
    for (genvar k = 0; k < FRAME_LEN; k++) begin : g_table
        assign rom_table[k] = pattern_sample(FRAME_ADDR_W'(k));
    end

    always_ff @(posedge clk_i) begin
        data_o <= rom_table[addr_i];
    end

    // The generator must never address past the end of the frame.
    a_addr_in_range : assert property (
        @(posedge clk_i) $isunknown(addr_i) || (int'(addr_i) < FRAME_LEN)
    ) else $error("iq_pattern_rom: address %0d beyond frame", addr_i);

endmodule

//--- source/iq_stream_pkg.sv
//**************************************************************************
// IQ stream package
// Shared widths, the I/Q sample word layout and the test-pattern table.
//**************************************************************************

package iq_stream_pkg;

    localparam int SAMPLE_W     = 16;
    localparam int PART_W       = 8;
    localparam int FRAME_LEN    = 66;
    localparam int FRAME_ADDR_W = $clog2(FRAME_LEN);
    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W   = $clog2(FIFO_DEPTH + 1);
    localparam int SUM_W        = 16;

    // I in the upper byte, Q in the lower byte.
    typedef struct packed {
        logic signed [PART_W-1:0] i;
        logic signed [PART_W-1:0] q;
    } iq_pair_t;

    typedef union packed {
        logic [SAMPLE_W-1:0] raw;
        iq_pair_t            iq;
    } iq_sample_t;

    // Pattern sample for one table address.
    function automatic iq_sample_t pattern_sample(input logic [FRAME_ADDR_W-1:0] addr);
        iq_sample_t sample;
        sample.iq.i = PART_W'(int'(addr) * 7);
        sample.iq.q = PART_W'(100 - int'(addr) * 3);
        return sample;
    endfunction

endpackage
